//--- Bender.yml
package:
  name: axi_sram

sources:
  # rtl in compile order, the settings header lives in the root.
  - include_dirs:
      - .
    files:
      - axi_sram_pkg.sv
      - axi_sram_array.sv
      - axi_sram_write_engine.sv
      - axi_sram_read_engine.sv
      - axi_sram_top.sv

  # self-checking testbench.
  - target: test
    files:
      - axi_sram_tb.sv

//--- axi_sram.f
+incdir+.
axi_sram_pkg.sv
axi_sram_array.sv
axi_sram_write_engine.sv
axi_sram_read_engine.sv
axi_sram_top.sv
axi_sram_tb.sv

//--- axi_sram_array.sv
// word memory with a strobed write port and a registered read port.
`include "axi_sram_settings.svh"

module axi_sram_array (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic                    mem_wr_en,
    input  axi_sram_pkg::mem_wr_t   mem_wr,
    input  logic                    mem_rd_en,
    input  axi_sram_pkg::word_idx_t mem_rd_idx,
    output axi_sram_pkg::data_t     mem_rd_data
);

    import axi_sram_pkg::*;

    localparam int DEPTH = 1 << `AXI_SRAM_MEM_ADDR_BITS;
    localparam int LANES = $bits(strb_t);

    data_t mem [DEPTH];

    // only the enabled byte lanes change.
    always_ff @(posedge ACLK) begin
        if (mem_wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (mem_wr.strb[i]) begin
                    mem[mem_wr.idx][i*8 +: 8] <= mem_wr.data[i*8 +: 8];
                end
            end
        end
    end

    // output register.
    // a same-edge write is not seen, the old word comes out.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            mem_rd_data <= '0;
        end else if (mem_rd_en) begin
            mem_rd_data <= mem[mem_rd_idx];
        end
    end

endmodule

//--- axi_sram_pkg.sv
// width typedefs, axi channel payload structs, memory port struct and engine states.
`include "axi_sram_settings.svh"

package axi_sram_pkg;

    // plain widths.
    typedef logic [`AXI_SRAM_ADDR_WIDTH-1:0]       addr_t;
    typedef logic [`AXI_SRAM_DATA_WIDTH-1:0]       data_t;
    typedef logic [`AXI_SRAM_DATA_WIDTH/8-1:0]     strb_t;
    typedef logic [`AXI_SRAM_ID_WIDTH-1:0]         id_t;
    typedef logic [7:0]                            len_t;
    typedef logic [1:0]                            resp_t;
    typedef logic [`AXI_SRAM_MEM_ADDR_BITS-1:0]    word_idx_t;

    // the only response this slave returns.
    localparam resp_t OKAY = 2'b00;

    // address channel payloads.
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } axi_aw_t;

    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } axi_ar_t;

    // write data beat.
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    // write response.
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } axi_b_t;

    // read data beat.
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

    // strobed write into the word array.
    typedef struct packed {
        word_idx_t idx;
        data_t     data;
        strb_t     strb;
    } mem_wr_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} write_state_e;

    typedef enum logic {RD_IDLE, RD_BURST} read_state_e;

endpackage

//--- axi_sram_read_engine.sv
// ar and r channel engine streaming a read burst from the array under back-pressure.
`include "axi_sram_settings.svh"

module axi_sram_read_engine (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    // ar channel.
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  axi_sram_pkg::axi_ar_t   ar,
    // r channel.
    output logic                    r_valid,
    input  logic                    r_ready,
    output axi_sram_pkg::axi_r_t    r,
    // memory read port.
    output logic                    mem_rd_en,
    output axi_sram_pkg::word_idx_t mem_rd_idx,
    input  axi_sram_pkg::data_t     mem_rd_data
);

    import axi_sram_pkg::*;

    read_state_e rd_state;
    word_idx_t   rd_start_idx;
    len_t        rd_len;
    len_t        rd_count;
    id_t         rd_id;

    logic      ar_fire;
    logic      r_fire;
    logic      rd_last;
    word_idx_t ar_start_idx;
    word_idx_t rd_next_idx;

    assign ar_ready = (rd_state == RD_IDLE);
    assign r_valid  = (rd_state == RD_BURST);

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;
    assign rd_last = (rd_count == rd_len);

    assign ar_start_idx = ar.addr[`AXI_SRAM_MEM_ADDR_BITS+1:2];
    assign rd_next_idx  = rd_start_idx + word_idx_t'(rd_count) + word_idx_t'(1);

    // one fetch runs ahead of the r channel.
    // beat 0 on the ar handshake, the next beat on each non-final handshake.
    always_comb begin
        mem_rd_en  = 1'b0;
        mem_rd_idx = rd_next_idx;
        if (ar_fire) begin
            mem_rd_en  = 1'b1;
            mem_rd_idx = ar_start_idx;
        end else if (r_fire && !rd_last) begin
            mem_rd_en = 1'b1;
        end
    end

    // control state.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            rd_state <= RD_IDLE;
            rd_count <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_count <= '0;
                        rd_state <= RD_BURST;
                    end
                end
                RD_BURST: begin
                    if (r_fire) begin
                        if (rd_last) begin
                            rd_state <= RD_IDLE;
                        end else begin
                            rd_count <= rd_count + len_t'(1);
                        end
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // burst parameters, taken on the ar handshake.
    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            rd_start_idx <= ar_start_idx;
            rd_len       <= ar.len;
            rd_id        <= ar.id;
        end
    end

    // payload holds while r_ready is low since no fetch is issued.
    assign r.id   = rd_id;
    assign r.data = mem_rd_data;
    assign r.resp = OKAY;
    assign r.last = rd_last;

endmodule

//--- axi_sram_settings.svh
// bus widths, id width and memory depth macros for the axi sram slave.
`ifndef AXI_SRAM_SETTINGS_SVH
`define AXI_SRAM_SETTINGS_SVH

// byte address width on the aw and ar channels.
`define AXI_SRAM_ADDR_WIDTH 32

// data bus width, one memory word per beat.
`define AXI_SRAM_DATA_WIDTH 32

// transaction id width.
`define AXI_SRAM_ID_WIDTH 4

// memory depth as a word index width.
// 10 bits gives 1024 words.
`define AXI_SRAM_MEM_ADDR_BITS 10

`endif

//--- axi_sram_tb.sv
// testbench with a reference memory, random bursts, a response compare process and a timeout.
module axi_sram_tb;

    import axi_sram_pkg::*;

    localparam int DEPTH         = 1 << $bits(word_idx_t);
    localparam int LANES         = $bits(strb_t);
    localparam int MAX_GAP       = 3;
    localparam int N_RAND        = 40;
    // beats of every planned burst, each written and then read back.
    localparam int PLANNED_BEATS = 2 * (1 + DEPTH + N_RAND * 16 + 8);
    localparam int CYCLE_LIMIT   = PLANNED_BEATS * (MAX_GAP + 2) + 4000;

    logic    ACLK;
    logic    ARESETn;
    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;

    data_t       ref_mem [DEPTH];
    logic [31:0] rng_state = 32'h90e2e69c;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycle_count = 0;

    // expected responses pushed by the stimulus and drained by the compare process.
    id_t       b_exp_q[$];
    id_t       rd_id_q[$];
    word_idx_t rd_idx_q[$];
    len_t      rd_len_q[$];
    int        rd_beat = 0;
    logic      b_stalled = 1'b0;
    logic      r_stalled = 1'b0;
    axi_b_t    b_held;
    axi_r_t    r_held;

    axi_sram_top dut_i (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    initial begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int random_gap();
        return int'(next_rand() % (MAX_GAP + 1));
    endfunction

    // drops the byte offset and wraps at the memory depth.
    function automatic word_idx_t beat_index(addr_t addr, int beat);
        return word_idx_t'((addr >> 2) + addr_t'(beat));
    endfunction

    // merge one beat into the reference memory under its strobes.
    function automatic void ref_write(word_idx_t idx, data_t data, strb_t strb);
        for (int i = 0; i < LANES; i++) begin
            if (strb[i]) begin
                ref_mem[idx][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endfunction

    function automatic data_t ref_read(word_idx_t idx);
        return ref_mem[idx];
    endfunction

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        value_errors++;
        $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic report_protocol(string what);
        protocol_errors++;
        $display("protocol error at t=%0t: %s", $time, what);
    endtask

    task automatic check_idle_outputs();
        if (aw_ready !== 1'b1) begin
            report_mismatch("aw_ready", 1, aw_ready);
        end
        if (ar_ready !== 1'b1) begin
            report_mismatch("ar_ready", 1, ar_ready);
        end
        if (w_ready !== 1'b0) begin
            report_mismatch("w_ready", 0, w_ready);
        end
        if (b_valid !== 1'b0) begin
            report_mismatch("b_valid", 0, b_valid);
        end
        if (r_valid !== 1'b0) begin
            report_mismatch("r_valid", 0, r_valid);
        end
    endtask

    task automatic run_write(id_t tid, addr_t addr, len_t len, logic full_strb);
        int     gap;
        axi_w_t beat;
        b_exp_q.push_back(tid);
        aw_valid <= 1'b1;
        aw       <= '{id: tid, addr: addr, len: len};
        @(posedge ACLK);
        while (!aw_ready) begin
            @(posedge ACLK);
        end
        aw_valid <= 1'b0;
        for (int n = 0; n <= int'(len); n++) begin
            gap = random_gap();
            if (gap > 0) begin
                w_valid <= 1'b0;
                repeat (gap) @(posedge ACLK);
            end
            beat.data = next_rand();
            beat.strb = full_strb ? '1 : strb_t'(next_rand());
            beat.last = (n == int'(len));
            w_valid <= 1'b1;
            w       <= beat;
            @(posedge ACLK);
            while (!w_ready) begin
                @(posedge ACLK);
            end
            ref_write(beat_index(addr, n), beat.data, beat.strb);
        end
        w_valid <= 1'b0;
        // hold b_ready low for a while once the response is up.
        while (!b_valid) begin
            @(posedge ACLK);
        end
        repeat (random_gap()) @(posedge ACLK);
        b_ready <= 1'b1;
        @(posedge ACLK);
        while (!b_valid) begin
            @(posedge ACLK);
        end
        b_ready <= 1'b0;
    endtask

    task automatic run_read(id_t tid, addr_t addr, len_t len);
        int   gap;
        logic done;
        rd_id_q.push_back(tid);
        rd_idx_q.push_back(beat_index(addr, 0));
        rd_len_q.push_back(len);
        ar_valid <= 1'b1;
        ar       <= '{id: tid, addr: addr, len: len};
        @(posedge ACLK);
        while (!ar_ready) begin
            @(posedge ACLK);
        end
        ar_valid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            gap = random_gap();
            r_ready <= 1'b0;
            repeat (gap) @(posedge ACLK);
            r_ready <= 1'b1;
            @(posedge ACLK);
            while (!r_valid) begin
                @(posedge ACLK);
            end
            done = r.last;
        end
        r_ready <= 1'b0;
    endtask

    // samples every handshake with the values seen before the edge.
    always @(posedge ACLK) begin : compare_responses
        id_t   exp_id;
        data_t exp_data;
        logic  exp_last;
        if (!ARESETn) begin
            b_stalled = 1'b0;
            r_stalled = 1'b0;
        end else begin
            if (b_stalled && !b_valid) begin
                report_protocol("b_valid dropped before b_ready");
            end else if (b_stalled && b !== b_held) begin
                report_mismatch("b held payload", b_held, b);
            end
            if (b_valid && b_exp_q.size() == 0) begin
                report_protocol("b_valid rose with no write burst open");
            end else if (b_valid && b_ready) begin
                exp_id = b_exp_q.pop_front();
                if (b.id !== exp_id) begin
                    report_mismatch("b.id", exp_id, b.id);
                end
                if (b.resp !== OKAY) begin
                    report_mismatch("b.resp", OKAY, b.resp);
                end
            end
            if (r_stalled && !r_valid) begin
                report_protocol("r_valid dropped before r_ready");
            end else if (r_stalled && r !== r_held) begin
                report_mismatch("r held payload", r_held, r);
            end
            if (r_valid && rd_id_q.size() == 0) begin
                report_protocol("r_valid rose with no read burst open");
            end else if (r_valid && r_ready) begin
                exp_data = ref_read(rd_idx_q[0] + word_idx_t'(rd_beat));
                exp_last = (rd_beat == int'(rd_len_q[0]));
                if (r.id !== rd_id_q[0]) begin
                    report_mismatch("r.id", rd_id_q[0], r.id);
                end
                if (r.data !== exp_data) begin
                    report_mismatch("r.data", exp_data, r.data);
                end
                if (r.resp !== OKAY) begin
                    report_mismatch("r.resp", OKAY, r.resp);
                end
                if (r.last !== exp_last) begin
                    report_mismatch("r.last", exp_last, r.last);
                end
                if (r.last) begin
                    if (rd_beat < int'(rd_len_q[0])) begin
                        report_protocol("fewer read beats than requested");
                    end
                    void'(rd_id_q.pop_front());
                    void'(rd_idx_q.pop_front());
                    void'(rd_len_q.pop_front());
                    rd_beat = 0;
                end else begin
                    rd_beat++;
                    if (rd_beat > int'(rd_len_q[0])) begin
                        report_protocol("more read beats than requested");
                    end
                end
            end
            b_stalled = b_valid && !b_ready;
            b_held    = b;
            r_stalled = r_valid && !r_ready;
            r_held    = r;
        end
    end

    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        addr_t addr;
        len_t  len;
        id_t   tid;
        ARESETn  <= 1'b0;
        aw_valid <= 1'b0;
        aw       <= '0;
        w_valid  <= 1'b0;
        w        <= '0;
        b_ready  <= 1'b0;
        ar_valid <= 1'b0;
        ar       <= '0;
        r_ready  <= 1'b0;
        // outputs settle after the first reset edge.
        for (int c = 0; c < 5; c++) begin
            @(posedge ACLK);
            if (c > 0) begin
                check_idle_outputs();
            end
        end
        ARESETn <= 1'b1;
        @(posedge ACLK);
        check_idle_outputs();

        addr = 32'h0000_0104;
        run_write(4'h3, addr, 8'd0, 1'b1);
        run_read(4'h9, addr, 8'd0);

        // 256 beat bursts fill the whole memory so later partial writes merge into known data.
        for (int k = 0; k < DEPTH / 256; k++) begin
            addr = addr_t'(k * 256 * 4);
            run_write(id_t'(k), addr, 8'd255, 1'b1);
            run_read(id_t'(k + 8), addr, 8'd255);
        end

        for (int k = 0; k < N_RAND; k++) begin
            addr = next_rand();
            len  = len_t'(next_rand() % 16);
            tid  = id_t'(next_rand());
            run_write(tid, addr, len, 1'b0);
            run_read(id_t'(next_rand()), addr, len);
        end

        // starts near the top of memory and crosses index 0.
        addr = (next_rand() & ~addr_t'(DEPTH * 4 - 1)) | addr_t'((DEPTH - 4) * 4);
        run_write(4'h5, addr, 8'd7, 1'b0);
        run_read(4'ha, addr, 8'd7);

        repeat (4) @(posedge ACLK);
        if (b_exp_q.size() != 0 || rd_id_q.size() != 0) begin
            report_protocol("responses still missing at the end of the run");
        end
        $display("run finished with %0d value errors and %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- axi_sram_top.sv
// top level joining the write engine, the read engine and the word array.
module axi_sram_top (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // write address.
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_sram_pkg::axi_aw_t aw,
    // write data.
    input  logic                  w_valid,
    output logic                  w_ready,
    input  axi_sram_pkg::axi_w_t  w,
    // write response.
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_sram_pkg::axi_b_t  b,
    // read address.
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_sram_pkg::axi_ar_t ar,
    // read data.
    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_sram_pkg::axi_r_t  r
);

    import axi_sram_pkg::*;

    logic      mem_wr_en;
    mem_wr_t   mem_wr;
    logic      mem_rd_en;
    word_idx_t mem_rd_idx;
    data_t     mem_rd_data;

    // write side.
    axi_sram_write_engine write_engine_i (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr)
    );

    // read side, runs independently of the write side.
    axi_sram_read_engine read_engine_i (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_idx  (mem_rd_idx),
        .mem_rd_data (mem_rd_data)
    );

    axi_sram_array array_i (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .mem_wr_en   (mem_wr_en),
        .mem_wr      (mem_wr),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_idx  (mem_rd_idx),
        .mem_rd_data (mem_rd_data)
    );

endmodule

//--- axi_sram_write_engine.sv
// aw, w and b channel engine turning a write burst into strobed memory writes.
`include "axi_sram_settings.svh"

module axi_sram_write_engine (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    // aw channel.
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_sram_pkg::axi_aw_t   aw,
    // w channel.
    input  logic                    w_valid,
    output logic                    w_ready,
    input  axi_sram_pkg::axi_w_t    w,
    // b channel.
    output logic                    b_valid,
    input  logic                    b_ready,
    output axi_sram_pkg::axi_b_t    b,
    // memory write port.
    output logic                    mem_wr_en,
    output axi_sram_pkg::mem_wr_t   mem_wr
);

    import axi_sram_pkg::*;

    write_state_e wr_state;
    word_idx_t    wr_start_idx;
    word_idx_t    wr_offset;
    id_t          wr_id;

    logic aw_fire;
    logic w_fire;
    logic b_fire;

    // ready and valid come straight from the state.
    assign aw_ready = (wr_state == WR_IDLE);
    assign w_ready  = (wr_state == WR_DATA);
    assign b_valid  = (wr_state == WR_RESP);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    // control state.
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            wr_state  <= WR_IDLE;
            wr_offset <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        wr_offset <= '0;
                        wr_state  <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // the burst ends on wlast, beats are not counted.
                    if (w_fire) begin
                        wr_offset <= wr_offset + word_idx_t'(1);
                        if (w.last) begin
                            wr_state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // burst start and id, taken on the aw handshake.
    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            wr_start_idx <= aw.addr[`AXI_SRAM_MEM_ADDR_BITS+1:2];
            wr_id        <= aw.id;
        end
    end

    // each accepted beat is written at its own edge.
    // index wraps modulo the depth.
    assign mem_wr_en   = w_fire;
    assign mem_wr.idx  = wr_start_idx + wr_offset;
    assign mem_wr.data = w.data;
    assign mem_wr.strb = w.strb;

    assign b.id   = wr_id;
    assign b.resp = OKAY;

endmodule
